/* vlog.f */
+incdir+bench
src/ltsm_pkg.sv
src/sb_serializer.sv
src/sb_deserializer.sv
src/ltsm_timers.sv
src/ltsm_fsm.sv
src/ltsm_phase_exchange.sv
src/ltsm_top.sv
bench/ltsm_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = ltsm_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the simulation prints the pass line
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

/* bench/sb_partner_tasks.svh */
// Message as the partner expects it, info and data always zero
function automatic sb_msg_t make_msg(input sb_msg_code_t code, input ltsm_state_t phase);
    sb_msg_t m;
    m          = '0;
    m.msg_code = code;
    m.sub_code = {5'b0, phase};
    return m;
endfunction

task automatic check_msg(input string what, input sb_msg_t exp, input sb_msg_t act);
    if (act !== exp) begin
        $display("Error %s (%s): expected %h, actual %h", test_name, what, exp, act);
        test_errors++;
    end
endtask

task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
        $display("Error %s (%s): expected %b, actual %b", test_name, what, exp, act);
        test_errors++;
    end
endtask

// Partner transmit, clock pin high for 64 cycles, msb first
task automatic send_msg(input sb_msg_t msg);
    logic [SB_MSG_W-1:0] bits;
    bits = msg;
    for (int i = SB_MSG_W - 1; i >= 0; i--) begin
        @(posedge clk_100MHz);
        sb_clk_pin_i  <= 1'b1;
        sb_data_pin_i <= bits[i];
    end
    @(posedge clk_100MHz);
    sb_clk_pin_i  <= 1'b0;
    sb_data_pin_i <= 1'b0;
endtask

// Partner receive, sampled on the falling edge while the DUT clock pin is high
task automatic recv_msg(output sb_msg_t msg, output int waited, output logic ok);
    logic [SB_MSG_W-1:0] bits;
    bits   = '0;
    waited = 0;
    ok     = 1'b1;
    @(negedge clk_100MHz);
    while (!sb_clk_pin_o && waited < STATE_TIMEOUT_CYCLES + RX_MARGIN) begin
        @(negedge clk_100MHz);
        waited++;
    end
    if (!sb_clk_pin_o) begin
        $display("%s: no sideband message from the DUT after %0d cycles", test_name, waited);
        test_errors++;
        ok = 1'b0;
    end
    for (int i = 0; i < SB_MSG_W && ok; i++) begin
        if (i > 0) begin
            @(negedge clk_100MHz);
        end
        if (!sb_clk_pin_o) begin
            $display("%s: DUT sideband clock dropped after %0d bits", test_name, i);
            test_errors++;
            ok = 1'b0;
        end
        bits = {bits[SB_MSG_W-2:0], sb_data_pin_o};
    end
    msg = sb_msg_t'(bits);
endtask

/* bench/ltsm_tb.sv */
`timescale 1ns/1ps

module ltsm_tb;

    import ltsm_pkg::*;

    // Slack on top of the longest phase timeout while waiting for a message
    localparam int RX_MARGIN = 1000;

    logic clk_100MHz = 1'b0;
    logic reset;
    logic enable_i;
    logic start_lt_i;
    logic sb_clk_pin_i;
    logic sb_data_pin_i;
    logic active_o;
    logic sb_clk_pin_o;
    logic sb_data_pin_o;

    string test_name;
    int    test_errors;
    int    pass_count;
    int    fail_count;

    always #5 clk_100MHz = ~clk_100MHz;

    ltsm_top ltsm_top_i (
        .clk_100MHz    (clk_100MHz),
        .reset         (reset),
        .enable_i      (enable_i),
        .start_lt_i    (start_lt_i),
        .sb_clk_pin_i  (sb_clk_pin_i),
        .sb_data_pin_i (sb_data_pin_i),
        .active_o      (active_o),
        .sb_clk_pin_o  (sb_clk_pin_o),
        .sb_data_pin_o (sb_data_pin_o)
    );

    `include "sb_partner_tasks.svh"

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            pass_count++;
            $display("PASS %s", test_name);
        end else begin
            fail_count++;
            $display("FAIL %s, %0d errors", test_name, test_errors);
        end
    endtask

    // Five reset cycles, enables set while reset is high
    task automatic apply_reset(input logic en, input logic st);
        @(posedge clk_100MHz);
        reset         <= 1'b1;
        enable_i      <= en;
        start_lt_i    <= st;
        sb_clk_pin_i  <= 1'b0;
        sb_data_pin_i <= 1'b0;
        repeat (5) @(posedge clk_100MHz);
        reset <= 1'b0;
    endtask

    // Sideband pins and active_o must stay low for the whole window
    task automatic hold_low(input int cycles);
        logic clk_seen;
        logic data_seen;
        logic act_seen;
        int   n;
        clk_seen  = 1'b0;
        data_seen = 1'b0;
        act_seen  = 1'b0;
        n         = 0;
        while (n < cycles && !(clk_seen || data_seen || act_seen)) begin
            @(negedge clk_100MHz);
            clk_seen  = sb_clk_pin_o;
            data_seen = sb_data_pin_o;
            act_seen  = active_o;
            n++;
        end
        check_bit("sb_clk_pin_o low", 1'b0, clk_seen);
        check_bit("sb_data_pin_o low", 1'b0, data_seen);
        check_bit("active_o low", 1'b0, act_seen);
    endtask

    task automatic reset_idle();
        begin_test("reset_idle");
        apply_reset(1'b0, 1'b0);
        hold_low(100);
        end_test();
    endtask

    task automatic enable_gate();
        begin_test("enable_gate");
        apply_reset(1'b0, 1'b1);
        hold_low(450_000);
        end_test();
    endtask

    task automatic dwell_then_sbinit();
        sb_msg_t got;
        int      waited;
        logic    ok;
        begin_test("dwell_then_sbinit");
        apply_reset(1'b1, 1'b1);
        hold_low(RESET_DWELL_CYCLES);
        recv_msg(got, waited, ok);
        if (ok) begin
            check_msg("first message", make_msg(MSG_REQ, SBINIT), got);
        end
        end_test();
    endtask

    task automatic full_training();
        ltsm_state_t phases [4];
        sb_msg_t     got;
        sb_msg_t     wrong;
        int          waited;
        int          n;
        logic        ok;
        phases = '{SBINIT, MBINIT, MBTRAIN, LINKINIT};
        ok     = 1'b1;
        begin_test("full_training");
        apply_reset(1'b1, 1'b1);
        for (int p = 0; p < 4 && ok; p++) begin
            recv_msg(got, waited, ok);
            if (ok) begin
                check_msg({phases[p].name(), " request"}, make_msg(MSG_REQ, phases[p]), got);
                send_msg(make_msg(MSG_REQ, phases[p]));
                recv_msg(got, waited, ok);
            end
            if (ok) begin
                check_msg({phases[p].name(), " response"}, make_msg(MSG_RSP, phases[p]), got);
                // Response tagged with the next phase, must not close this one
                wrong          = make_msg(MSG_RSP, phases[p]);
                wrong.sub_code = wrong.sub_code + 8'd1;
                send_msg(wrong);
                hold_low(20);
                send_msg(make_msg(MSG_RSP, phases[p]));
            end
        end
        if (ok) begin
            n = 0;
            while (!active_o && n < 100) begin
                @(negedge clk_100MHz);
                n++;
            end
            check_bit("active after LINKINIT", 1'b1, active_o);
        end
        end_test();
    endtask

    task automatic timeout_error();
        sb_msg_t got;
        int      waited;
        logic    ok;
        begin_test("timeout_error");
        apply_reset(1'b1, 1'b1);
        recv_msg(got, waited, ok);
        if (ok) begin
            check_msg("opening request", make_msg(MSG_REQ, SBINIT), got);
            // Partner stays silent from here on
            recv_msg(got, waited, ok);
        end
        if (ok) begin
            check_msg("error message", make_msg(MSG_ERR, TRAINERROR), got);
            recv_msg(got, waited, ok);
        end
        if (ok) begin
            check_msg("retry request", make_msg(MSG_REQ, SBINIT), got);
            // First ERR bit to first retry bit spans the full dwell
            check_bit("dwell before retry", 1'b1, (SB_MSG_W + waited) >= RESET_DWELL_CYCLES);
        end
        end_test();
    endtask

    initial begin
        reset         = 1'b1;
        enable_i      = 1'b0;
        start_lt_i    = 1'b0;
        sb_clk_pin_i  = 1'b0;
        sb_data_pin_i = 1'b0;
        pass_count    = 0;
        fail_count    = 0;
        reset_idle();
        enable_gate();
        dwell_then_sbinit();
        full_training();
        timeout_error();
        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* src/ltsm_top.sv */
`timescale 1ns/1ps

module ltsm_top (
    input  logic clk_100MHz,
    input  logic reset,
    input  logic enable_i,
    input  logic start_lt_i,
    input  logic sb_clk_pin_i,
    input  logic sb_data_pin_i,
    output logic active_o,
    output logic sb_clk_pin_o,
    output logic sb_data_pin_o
);

    import ltsm_pkg::*;

    ltsm_state_t state;
    logic        dwell_done;
    logic        timeout;
    logic        phase_done;

    sb_msg_t     tx_msg;
    logic        tx_start;
    logic        tx_busy;
    sb_msg_t     rx_msg;
    logic        rx_valid;

    ltsm_fsm ltsm_fsm_i (
        .clk_100MHz   (clk_100MHz),
        .reset        (reset),
        .enable_i     (enable_i),
        .start_lt_i   (start_lt_i),
        .dwell_done_i (dwell_done),
        .timeout_i    (timeout),
        .phase_done_i (phase_done),
        .state_o      (state),
        .active_o     (active_o)
    );

    ltsm_timers ltsm_timers_i (
        .clk_100MHz   (clk_100MHz),
        .reset        (reset),
        .state_i      (state),
        .dwell_done_o (dwell_done),
        .timeout_o    (timeout)
    );

    ltsm_phase_exchange ltsm_phase_exchange_i (
        .clk_100MHz   (clk_100MHz),
        .reset        (reset),
        .state_i      (state),
        .rx_msg_i     (rx_msg),
        .rx_valid_i   (rx_valid),
        .tx_busy_i    (tx_busy),
        .tx_msg_o     (tx_msg),
        .tx_start_o   (tx_start),
        .phase_done_o (phase_done)
    );

    sb_serializer sb_serializer_i (
        .clk_100MHz    (clk_100MHz),
        .reset         (reset),
        .msg_i         (tx_msg),
        .start_i       (tx_start),
        .busy_o        (tx_busy),
        .sb_clk_pin_o  (sb_clk_pin_o),
        .sb_data_pin_o (sb_data_pin_o)
    );

    sb_deserializer sb_deserializer_i (
        .clk_100MHz    (clk_100MHz),
        .reset         (reset),
        .sb_clk_pin_i  (sb_clk_pin_i),
        .sb_data_pin_i (sb_data_pin_i),
        .msg_o         (rx_msg),
        .valid_o       (rx_valid)
    );

endmodule

/* src/ltsm_phase_exchange.sv */
`timescale 1ns/1ps

module ltsm_phase_exchange (
    input  logic                  clk_100MHz,
    input  logic                  reset,
    input  ltsm_pkg::ltsm_state_t state_i,
    input  ltsm_pkg::sb_msg_t     rx_msg_i,
    input  logic                  rx_valid_i,
    input  logic                  tx_busy_i,
    output ltsm_pkg::sb_msg_t     tx_msg_o,
    output logic                  tx_start_o,
    output logic                  phase_done_o
);

    import ltsm_pkg::*;

    ltsm_state_t state_q;
    logic        entry;
    logic        training;
    logic        error_phase;
    logic [7:0]  phase_code;
    logic        rx_match;

    // Phase flags
    logic        req_pend;
    logic        rsp_pend;
    logic        rsp_sent;
    logic        peer_rsp_seen;

    logic        issue;
    sb_msg_t     next_msg;

    assign entry       = (state_i != state_q);
    assign training    = state_i inside {SBINIT, MBINIT, MBTRAIN, LINKINIT};
    assign error_phase = (state_i == TRAINERROR);
    assign phase_code  = {5'b0, state_i};
    assign rx_match    = rx_valid_i && training && (rx_msg_i.sub_code == phase_code);

    // One start per free transmitter, never in the cycle of phase_done
    assign issue = !entry && !tx_start_o && !tx_busy_i && !phase_done_o
                   && (req_pend || rsp_pend);

    always_comb begin
        next_msg          = '0;
        next_msg.sub_code = phase_code;
        if (req_pend) begin
            next_msg.msg_code = error_phase ? MSG_ERR : MSG_REQ;
        end else begin
            next_msg.msg_code = MSG_RSP;
        end
    end

    always_ff @(posedge clk_100MHz) begin
        if (reset) begin
            state_q       <= RESET;
            req_pend      <= 1'b0;
            rsp_pend      <= 1'b0;
            rsp_sent      <= 1'b0;
            peer_rsp_seen <= 1'b0;
            tx_start_o    <= 1'b0;
            phase_done_o  <= 1'b0;
        end else begin
            state_q      <= state_i;
            tx_start_o   <= 1'b0;
            phase_done_o <= 1'b0;
            if (entry) begin
                // New phase, opening message is REQ or ERR
                req_pend      <= training || error_phase;
                rsp_pend      <= 1'b0;
                rsp_sent      <= 1'b0;
                peer_rsp_seen <= 1'b0;
            end else begin
                // Start strobe high means the serializer takes the word now
                if (tx_start_o && tx_msg_o.msg_code != MSG_REQ) begin
                    rsp_sent <= 1'b1;
                end
                if (issue) begin
                    tx_start_o <= 1'b1;
                    if (req_pend) begin
                        req_pend <= 1'b0;
                    end else begin
                        rsp_pend <= 1'b0;
                    end
                end
                if (rsp_sent && (peer_rsp_seen || error_phase) && !phase_done_o) begin
                    phase_done_o  <= 1'b1;
                    rsp_sent      <= 1'b0;
                    peer_rsp_seen <= 1'b0;
                end
            end
            // Partner traffic for this phase, may land on the entry cycle too
            if (rx_match && rx_msg_i.msg_code == MSG_REQ) begin
                rsp_pend <= 1'b1;
            end
            if (rx_match && rx_msg_i.msg_code == MSG_RSP) begin
                peer_rsp_seen <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_100MHz) begin
        if (issue) begin
            tx_msg_o <= next_msg;
        end
    end

    // Relies on the serializer raising busy on the edge it takes start
    start_only_when_idle: assert property (@(posedge clk_100MHz) disable iff (reset)
        !(tx_start_o && tx_busy_i));

endmodule

/* src/ltsm_fsm.sv */
`timescale 1ns/1ps

module ltsm_fsm (
    input  logic                  clk_100MHz,
    input  logic                  reset,
    input  logic                  enable_i,
    input  logic                  start_lt_i,
    input  logic                  dwell_done_i,
    input  logic                  timeout_i,
    input  logic                  phase_done_i,
    output ltsm_pkg::ltsm_state_t state_o,
    output logic                  active_o
);

    import ltsm_pkg::*;

    ltsm_state_t state_d;
    logic        training;

    assign training = state_o inside {SBINIT, MBINIT, MBTRAIN, LINKINIT};

    always_comb begin
        state_d = state_o;
        if (training && timeout_i) begin
            // Timeout wins over a phase that finishes in the same cycle
            state_d = TRAINERROR;
        end else begin
            case (state_o)
                RESET: begin
                    if (dwell_done_i && enable_i && start_lt_i) begin
                        state_d = SBINIT;
                    end
                end
                SBINIT: begin
                    if (phase_done_i) begin
                        state_d = MBINIT;
                    end
                end
                MBINIT: begin
                    if (phase_done_i) begin
                        state_d = MBTRAIN;
                    end
                end
                MBTRAIN: begin
                    if (phase_done_i) begin
                        state_d = LINKINIT;
                    end
                end
                LINKINIT: begin
                    if (phase_done_i) begin
                        state_d = ACTIVE;
                    end
                end
                // Link stays up until the next reset
                ACTIVE: state_d = ACTIVE;
                TRAINERROR: begin
                    // Error message is out, start over
                    if (phase_done_i) begin
                        state_d = RESET;
                    end
                end
                default: state_d = RESET;
            endcase
        end
    end

    always_ff @(posedge clk_100MHz) begin
        if (reset) begin
            state_o <= RESET;
        end else begin
            state_o <= state_d;
        end
    end

    assign active_o = (state_o == ACTIVE);

    active_is_final: assert property (@(posedge clk_100MHz) disable iff (reset)
        state_o == ACTIVE |=> state_o == ACTIVE);

    // Phase exchange must be idle while the dwell runs
    no_done_in_reset: assert property (@(posedge clk_100MHz) disable iff (reset)
        state_o == RESET |-> !phase_done_i);

endmodule

/* src/ltsm_timers.sv */
`timescale 1ns/1ps

module ltsm_timers (
    input  logic                  clk_100MHz,
    input  logic                  reset,
    input  ltsm_pkg::ltsm_state_t state_i,
    output logic                  dwell_done_o,
    output logic                  timeout_o
);

    import ltsm_pkg::*;

    logic [DWELL_CNT_W-1:0]   dwell_cnt;
    logic [TIMEOUT_CNT_W-1:0] timeout_cnt;
    ltsm_state_t              state_q;
    logic                     training;

    assign training = state_i inside {SBINIT, MBINIT, MBTRAIN, LINKINIT};

    // RESET dwell, holds at the end value until RESET is left
    always_ff @(posedge clk_100MHz) begin
        if (reset) begin
            dwell_cnt <= '0;
        end else if (state_i != RESET) begin
            dwell_cnt <= '0;
        end else if (!dwell_done_o) begin
            dwell_cnt <= dwell_cnt + 1'b1;
        end
    end

    assign dwell_done_o = (dwell_cnt == DWELL_CNT_W'(RESET_DWELL_CYCLES - 1));

    // Per-state timeout, restarted on every state change
    always_ff @(posedge clk_100MHz) begin
        if (reset) begin
            state_q     <= RESET;
            timeout_cnt <= '0;
        end else begin
            state_q <= state_i;
            if (state_i != state_q || !training) begin
                timeout_cnt <= '0;
            end else if (!timeout_o) begin
                timeout_cnt <= timeout_cnt + 1'b1;
            end
        end
    end

    assign timeout_o = (timeout_cnt == TIMEOUT_CNT_W'(STATE_TIMEOUT_CYCLES - 1));

endmodule

/* src/sb_deserializer.sv */
`timescale 1ns/1ps

module sb_deserializer (
    input  logic              clk_100MHz,
    input  logic              reset,
    input  logic              sb_clk_pin_i,
    input  logic              sb_data_pin_i,
    output ltsm_pkg::sb_msg_t msg_o,
    output logic              valid_o
);

    import ltsm_pkg::*;

    logic [SB_MSG_W-1:0] shift_q;
    logic [SB_CNT_W-1:0] bit_cnt;

    // Count bits while the partner clock is high, drop short bursts
    always_ff @(posedge clk_100MHz) begin
        if (reset) begin
            bit_cnt <= '0;
            valid_o <= 1'b0;
        end else begin
            valid_o <= 1'b0;
            if (!sb_clk_pin_i) begin
                bit_cnt <= '0;
            end else if (bit_cnt == SB_CNT_W'(SB_MSG_W - 1)) begin
                bit_cnt <= '0;
                valid_o <= 1'b1;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_100MHz) begin
        if (sb_clk_pin_i) begin
            shift_q <= {shift_q[SB_MSG_W-2:0], sb_data_pin_i};
        end
    end

    assign msg_o = sb_msg_t'(shift_q);

    // Each word needs 64 clock-high cycles before the next pulse
    single_cycle_valid: assert property (@(posedge clk_100MHz) disable iff (reset)
        valid_o |=> !valid_o);

endmodule

/* src/sb_serializer.sv */
`timescale 1ns/1ps

module sb_serializer (
    input  logic              clk_100MHz,
    input  logic              reset,
    input  ltsm_pkg::sb_msg_t msg_i,
    input  logic              start_i,
    output logic              busy_o,
    output logic              sb_clk_pin_o,
    output logic              sb_data_pin_o
);

    import ltsm_pkg::*;

    logic [SB_MSG_W-1:0] shift_q;
    logic [SB_CNT_W-1:0] bit_cnt;

    // Busy covers the 64 bit times after the start edge
    always_ff @(posedge clk_100MHz) begin
        if (reset) begin
            busy_o  <= 1'b0;
            bit_cnt <= '0;
        end else if (!busy_o) begin
            if (start_i) begin
                busy_o  <= 1'b1;
                bit_cnt <= SB_CNT_W'(SB_MSG_W - 1);
            end
        end else begin
            bit_cnt <= bit_cnt - 1'b1;
            if (bit_cnt == '0) begin
                busy_o <= 1'b0;
            end
        end
    end

    // Msb first
    always_ff @(posedge clk_100MHz) begin
        if (!busy_o && start_i) begin
            shift_q <= msg_i;
        end else if (busy_o) begin
            shift_q <= {shift_q[SB_MSG_W-2:0], 1'b0};
        end
    end

    // Both pins quiet when idle
    assign sb_clk_pin_o  = busy_o;
    assign sb_data_pin_o = busy_o && shift_q[SB_MSG_W-1];

endmodule

/* src/ltsm_pkg.sv */
package ltsm_pkg;

    // Sideband word and bit counter widths
    localparam int SB_MSG_W = 64;
    localparam int SB_CNT_W = $clog2(SB_MSG_W);

    // 4 ms and 8 ms at 100 MHz
    localparam int RESET_DWELL_CYCLES   = 400_000;
    localparam int STATE_TIMEOUT_CYCLES = 800_000;

    localparam int DWELL_CNT_W   = 19;
    localparam int TIMEOUT_CNT_W = 20;

    // Training states, code 6 left free
    typedef enum logic [2:0] {
        RESET      = 3'd0,
        SBINIT     = 3'd1,
        MBINIT     = 3'd2,
        MBTRAIN    = 3'd3,
        LINKINIT   = 3'd4,
        ACTIVE     = 3'd5,
        TRAINERROR = 3'd7
    } ltsm_state_t;

    // Sideband message kinds
    typedef enum logic [7:0] {
        MSG_REQ = 8'h01,
        MSG_RSP = 8'h02,
        MSG_ERR = 8'h03
    } sb_msg_code_t;

    // One sideband message, msb goes out first
    typedef struct packed {
        sb_msg_code_t msg_code;
        // Phase the message belongs to, state code zero extended
        logic [7:0]   sub_code;
        logic [15:0]  msg_info;
        logic [31:0]  data;
    } sb_msg_t;

endpackage
